// ==== rtl/fb_axi_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Framebuffer memory side definitions
// Read response codes and address channel field widths shared by the
// request generator, the serializer and the memory model
//////////////////////////////////////////////////////////////////////

package fb_axi_pkg;

    //////////////////////////////////////////////////////////////////////
    // Address channel
    //////////////////////////////////////////////////////////////////////

    // Burst length field, always driven as zero (one beat per read)
    parameter int AXI_LEN_W = 8;

    //////////////////////////////////////////////////////////////////////
    // Data channel
    //////////////////////////////////////////////////////////////////////

    parameter int AXI_RESP_W = 2;

    // Read response codes
    typedef enum logic [AXI_RESP_W-1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

// ==== rtl/fb_fetch_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Framebuffer fetch side definitions
// Controller state encodings of the read request generator and the
// fragment output register
//////////////////////////////////////////////////////////////////////

package fb_fetch_pkg;

    // Read request generator
    // REQ_IDLE waits for a fetch, REQ_ADDR holds arvalid until arready
    typedef enum logic {
        REQ_IDLE = 1'b0,
        REQ_ADDR = 1'b1
    } req_state_e;

    // Fragment output register
    typedef enum logic {
        OUT_EMPTY = 1'b0,
        OUT_FULL  = 1'b1
    } ser_state_e;

endpackage

// ==== rtl/fetch_broadcast.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch broadcast
// Copies each fetch request to the read request generator and to the
// index FIFO, and acknowledges the source once both have taken it
//////////////////////////////////////////////////////////////////////

module fetch_broadcast #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                    aclk,
    input  logic                    i_rst,

    // Source side
    input  logic                    i_valid,
    input  logic                    i_last,
    input  logic [ADDR_WIDTH-1:0]   i_index,
    output logic                    o_ready,

    // Request generator side
    output logic                    o_gen_valid,
    output logic [ADDR_WIDTH-1:0]   o_gen_index,
    input  logic                    i_gen_ready,

    // Index FIFO side
    output logic                    o_fifo_wr,
    output logic [ADDR_WIDTH-1:0]   o_fifo_index,
    output logic                    o_fifo_last,
    input  logic                    i_fifo_full
);

    // Consumer already holds the current request
    logic gen_taken;
    logic fifo_taken;

    logic gen_done;
    logic fifo_done;

    assign o_gen_valid  = i_valid && !gen_taken;
    assign o_gen_index  = i_index;

    // Write only into free space
    assign o_fifo_wr    = i_valid && !fifo_taken && !i_fifo_full;
    assign o_fifo_index = i_index;
    assign o_fifo_last  = i_last;

    assign gen_done  = gen_taken || i_gen_ready;
    assign fifo_done = fifo_taken || !i_fifo_full;
    assign o_ready   = gen_done && fifo_done;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            gen_taken  <= 1'b0;
            fifo_taken <= 1'b0;
        end else if (i_valid && o_ready) begin
            // Source released, next request starts fresh
            gen_taken  <= 1'b0;
            fifo_taken <= 1'b0;
        end else begin
            if (o_gen_valid && i_gen_ready)
                gen_taken <= 1'b1;
            if (o_fifo_wr)
                fifo_taken <= 1'b1;
        end
    end

endmodule

// ==== rtl/fetch_index_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch index FIFO
// First-word-fall-through queue of the index and last flag of every
// read still in flight, kept in request order
//////////////////////////////////////////////////////////////////////

module fetch_index_fifo #(
    parameter int ADDR_WIDTH      = 32,
    parameter int FIFO_DEPTH_LOG2 = 7
) (
    input  logic                    aclk,
    input  logic                    i_rst,

    // Write side
    input  logic                    i_wr,
    input  logic [ADDR_WIDTH-1:0]   i_index,
    input  logic                    i_last,
    output logic                    o_full,

    // Read side, head is always visible
    input  logic                    i_rd,
    output logic [ADDR_WIDTH-1:0]   o_index,
    output logic                    o_last,
    output logic                    o_empty
);

    localparam int DEPTH  = 1 << FIFO_DEPTH_LOG2;
    localparam int ENTRY_W = ADDR_WIDTH + 1;

    // Entry layout is {last, index}
    logic [ENTRY_W-1:0]         mem [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]   count;

    logic push;
    logic pop;

    assign o_full  = (count == (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
    assign o_empty = (count == '0);

    assign push = i_wr && !o_full;
    assign pop  = i_rd && !o_empty;

    assign o_index = mem[rd_ptr][ADDR_WIDTH-1:0];
    assign o_last  = mem[rd_ptr][ADDR_WIDTH];

    // Storage
    always_ff @(posedge aclk) begin
        if (push)
            mem[wr_ptr] <= {i_last, i_index};
    end

    // Pointers and occupancy, pointers wrap naturally
    always_ff @(posedge aclk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

// ==== rtl/mem_read_request_gen.sv ====
//////////////////////////////////////////////////////////////////////
// Memory read request generator
// Turns fetch indices into beat-aligned single-beat read requests
// relative to the configured framebuffer base address
//////////////////////////////////////////////////////////////////////

module mem_read_request_gen #(
    parameter int STREAM_WIDTH = 32,
    parameter int ADDR_WIDTH   = 32,
    parameter int PIXEL_WIDTH  = 16
) (
    input  logic                            aclk,
    input  logic                            i_rst,

    // Framebuffer base address
    input  logic [ADDR_WIDTH-1:0]           i_conf_addr,

    // Fetch side
    input  logic                            i_valid,
    input  logic [ADDR_WIDTH-1:0]           i_index,
    output logic                            o_ready,

    // Memory address channel
    output logic [ADDR_WIDTH-1:0]           o_mem_araddr,
    output logic [fb_axi_pkg::AXI_LEN_W-1:0] o_mem_arlen,
    output logic                            o_mem_arvalid,
    input  logic                            i_mem_arready
);

    import fb_fetch_pkg::*;

    localparam int PIXEL_BYTES = PIXEL_WIDTH / 8;
    localparam int BEAT_BYTES  = STREAM_WIDTH / 8;
    localparam int PIX_SHIFT   = $clog2(PIXEL_BYTES);

    // Clears the byte offset inside one beat
    localparam logic [ADDR_WIDTH-1:0] BEAT_MASK = ~(ADDR_WIDTH'(BEAT_BYTES - 1));

    req_state_e             state;
    logic [ADDR_WIDTH-1:0]  byte_addr;
    logic                   accept;

    // Pixel byte address, rounded down to the beat below
    assign byte_addr = i_conf_addr + (i_index << PIX_SHIFT);

    assign o_ready       = (state == REQ_IDLE);
    assign accept        = i_valid && o_ready;
    assign o_mem_arvalid = (state == REQ_ADDR);

    // Single beat per read
    assign o_mem_arlen = '0;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            state <= REQ_IDLE;
        end else begin
            case (state)
                REQ_IDLE: begin
                    if (accept)
                        state <= REQ_ADDR;
                end
                REQ_ADDR: begin
                    if (i_mem_arready)
                        state <= REQ_IDLE;
                end
                default: state <= REQ_IDLE;
            endcase
        end
    end

    // Address only loads in REQ_IDLE, so it is stable while arvalid is high
    always_ff @(posedge aclk) begin
        if (accept)
            o_mem_araddr <= byte_addr & BEAT_MASK;
    end

endmodule

// ==== rtl/fb_serializer.sv ====
//////////////////////////////////////////////////////////////////////
// Framebuffer serializer
// Pairs each read beat with the oldest queued index, selects that
// pixel's lane and holds the fragment in a registered output stage
//////////////////////////////////////////////////////////////////////

module fb_serializer #(
    parameter int STREAM_WIDTH = 32,
    parameter int ADDR_WIDTH   = 32,
    parameter int PIXEL_WIDTH  = 16
) (
    input  logic                        aclk,
    input  logic                        i_rst,

    // Index FIFO head
    input  logic [ADDR_WIDTH-1:0]       i_fifo_index,
    input  logic                        i_fifo_last,
    input  logic                        i_fifo_empty,
    output logic                        o_fifo_rd,

    // Memory data channel
    input  logic [STREAM_WIDTH-1:0]     i_mem_rdata,
    input  fb_axi_pkg::axi_resp_e       i_mem_rresp,
    input  logic                        i_mem_rvalid,
    input  logic                        i_mem_rlast,
    output logic                        o_mem_rready,

    // Fragment output
    output logic                        o_frag_valid,
    input  logic                        i_frag_ready,
    output logic [PIXEL_WIDTH-1:0]      o_frag_data,
    output logic [ADDR_WIDTH-1:0]       o_frag_index,
    output logic                        o_frag_last,
    output logic                        o_frag_err
);

    import fb_axi_pkg::*;
    import fb_fetch_pkg::*;

    localparam int PIXELS_PER_BEAT = STREAM_WIDTH / PIXEL_WIDTH;
    localparam int LANE_W = (PIXELS_PER_BEAT > 1) ? $clog2(PIXELS_PER_BEAT) : 1;

    ser_state_e             state;
    logic                   out_free;
    logic                   beat_acc;
    logic [LANE_W-1:0]      lane;
    logic [PIXEL_WIDTH-1:0] beat_pixel;
    logic                   beat_err;

    //////////////////////////////////////////////////////////////////////
    // Beat acceptance
    //////////////////////////////////////////////////////////////////////

    // Output register is empty or drains this cycle
    assign out_free     = (state == OUT_EMPTY) || i_frag_ready;
    assign o_mem_rready = !i_fifo_empty && out_free;
    assign beat_acc     = i_mem_rvalid && o_mem_rready;
    assign o_fifo_rd    = beat_acc;

    // Lane comes from the low index bits
    assign lane       = LANE_W'(i_fifo_index % PIXELS_PER_BEAT);
    assign beat_pixel = i_mem_rdata[lane * PIXEL_WIDTH +: PIXEL_WIDTH];

    // Single beat reads must always carry rlast
    assign beat_err = (i_mem_rresp != OKAY) || !i_mem_rlast;

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    assign o_frag_valid = (state == OUT_FULL);

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            state <= OUT_EMPTY;
        end else if (beat_acc) begin
            state <= OUT_FULL;
        end else if (i_frag_ready) begin
            state <= OUT_EMPTY;
        end
    end

    // Fields only load on a beat, which needs the register free
    always_ff @(posedge aclk) begin
        if (beat_acc) begin
            o_frag_data  <= beat_pixel;
            o_frag_index <= i_fifo_index;
            o_frag_last  <= i_fifo_last;
            o_frag_err   <= beat_err;
        end
    end

endmodule

// ==== rtl/framebuffer_reader.sv ====
//////////////////////////////////////////////////////////////////////
// Framebuffer reader
// Read path of the rasterizer framebuffer: fetch requests become
// single-beat memory reads, and read beats become pixel fragments
//////////////////////////////////////////////////////////////////////

module framebuffer_reader #(
    parameter int STREAM_WIDTH    = 32,
    parameter int ADDR_WIDTH      = 32,
    parameter int PIXEL_WIDTH     = 16,
    parameter int FIFO_DEPTH_LOG2 = 7
) (
    input  logic                            aclk,
    input  logic                            i_rst,

    // Configuration
    input  logic [ADDR_WIDTH-1:0]           i_conf_addr,

    // Fetch port
    input  logic                            i_fetch_valid,
    input  logic                            i_fetch_last,
    input  logic [ADDR_WIDTH-1:0]           i_fetch_index,
    output logic                            o_fetch_ready,

    // Memory address channel
    output logic [ADDR_WIDTH-1:0]           o_mem_araddr,
    output logic [fb_axi_pkg::AXI_LEN_W-1:0] o_mem_arlen,
    output logic                            o_mem_arvalid,
    input  logic                            i_mem_arready,

    // Memory data channel
    input  logic [STREAM_WIDTH-1:0]         i_mem_rdata,
    input  fb_axi_pkg::axi_resp_e           i_mem_rresp,
    input  logic                            i_mem_rlast,
    input  logic                            i_mem_rvalid,
    output logic                            o_mem_rready,

    // Fragment port
    output logic                            o_frag_valid,
    input  logic                            i_frag_ready,
    output logic [PIXEL_WIDTH-1:0]          o_frag_data,
    output logic [ADDR_WIDTH-1:0]           o_frag_index,
    output logic                            o_frag_last,
    output logic                            o_frag_err
);

    //////////////////////////////////////////////////////////////////////
    // Internal wiring
    //////////////////////////////////////////////////////////////////////

    logic                   gen_valid;
    logic                   gen_ready;
    logic [ADDR_WIDTH-1:0]  gen_index;

    logic                   fifo_wr;
    logic                   fifo_full;
    logic [ADDR_WIDTH-1:0]  fifo_wr_index;
    logic                   fifo_wr_last;

    logic                   fifo_rd;
    logic                   fifo_empty;
    logic [ADDR_WIDTH-1:0]  fifo_index;
    logic                   fifo_last;

    //////////////////////////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////////////////////////

    fetch_broadcast #(
        .ADDR_WIDTH   (ADDR_WIDTH)
    ) i_fetch_broadcast (
        .aclk         (aclk),
        .i_rst        (i_rst),
        .i_valid      (i_fetch_valid),
        .i_last       (i_fetch_last),
        .i_index      (i_fetch_index),
        .o_ready      (o_fetch_ready),
        .o_gen_valid  (gen_valid),
        .o_gen_index  (gen_index),
        .i_gen_ready  (gen_ready),
        .o_fifo_wr    (fifo_wr),
        .o_fifo_index (fifo_wr_index),
        .o_fifo_last  (fifo_wr_last),
        .i_fifo_full  (fifo_full)
    );

    fetch_index_fifo #(
        .ADDR_WIDTH      (ADDR_WIDTH),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) i_fetch_index_fifo (
        .aclk    (aclk),
        .i_rst   (i_rst),
        .i_wr    (fifo_wr),
        .i_index (fifo_wr_index),
        .i_last  (fifo_wr_last),
        .o_full  (fifo_full),
        .i_rd    (fifo_rd),
        .o_index (fifo_index),
        .o_last  (fifo_last),
        .o_empty (fifo_empty)
    );

    //////////////////////////////////////////////////////////////////////
    // Read requests
    //////////////////////////////////////////////////////////////////////

    mem_read_request_gen #(
        .STREAM_WIDTH  (STREAM_WIDTH),
        .ADDR_WIDTH    (ADDR_WIDTH),
        .PIXEL_WIDTH   (PIXEL_WIDTH)
    ) i_mem_read_request_gen (
        .aclk          (aclk),
        .i_rst         (i_rst),
        .i_conf_addr   (i_conf_addr),
        .i_valid       (gen_valid),
        .i_index       (gen_index),
        .o_ready       (gen_ready),
        .o_mem_araddr  (o_mem_araddr),
        .o_mem_arlen   (o_mem_arlen),
        .o_mem_arvalid (o_mem_arvalid),
        .i_mem_arready (i_mem_arready)
    );

    //////////////////////////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////////////////////////

    fb_serializer #(
        .STREAM_WIDTH (STREAM_WIDTH),
        .ADDR_WIDTH   (ADDR_WIDTH),
        .PIXEL_WIDTH  (PIXEL_WIDTH)
    ) i_fb_serializer (
        .aclk         (aclk),
        .i_rst        (i_rst),
        .i_fifo_index (fifo_index),
        .i_fifo_last  (fifo_last),
        .i_fifo_empty (fifo_empty),
        .o_fifo_rd    (fifo_rd),
        .i_mem_rdata  (i_mem_rdata),
        .i_mem_rresp  (i_mem_rresp),
        .i_mem_rvalid (i_mem_rvalid),
        .i_mem_rlast  (i_mem_rlast),
        .o_mem_rready (o_mem_rready),
        .o_frag_valid (o_frag_valid),
        .i_frag_ready (i_frag_ready),
        .o_frag_data  (o_frag_data),
        .o_frag_index (o_frag_index),
        .o_frag_last  (o_frag_last),
        .o_frag_err   (o_frag_err)
    );

endmodule

// ==== tb/framebuffer_reader_props.sv ====
//////////////////////////////////////////////////////////////////////
// Framebuffer reader handshake properties
// Bound to the top level to check channel stability and FIFO use
//////////////////////////////////////////////////////////////////////

module framebuffer_reader_props #(
    parameter int ADDR_WIDTH  = 32,
    parameter int PIXEL_WIDTH = 16
) (
    input logic                     aclk,
    input logic                     i_rst,
    input logic [ADDR_WIDTH-1:0]    o_mem_araddr,
    input logic                     o_mem_arvalid,
    input logic                     i_mem_arready,
    input logic                     o_mem_rready,
    input logic                     o_frag_valid,
    input logic                     i_frag_ready,
    input logic [PIXEL_WIDTH-1:0]   o_frag_data,
    input logic [ADDR_WIDTH-1:0]    o_frag_index,
    input logic                     o_frag_last,
    input logic                     o_frag_err,
    input logic                     fifo_wr,
    input logic                     fifo_full,
    input logic                     fifo_empty
);

    // Address channel holds until accepted
    ar_hold: assert property (@(posedge aclk) disable iff (i_rst)
        o_mem_arvalid && !i_mem_arready |=> o_mem_arvalid && $stable(o_mem_araddr))
        else $error("read address changed before arready");

    frag_hold: assert property (@(posedge aclk) disable iff (i_rst)
        o_frag_valid && !i_frag_ready |=> o_frag_valid && $stable(o_frag_data)
            && $stable(o_frag_index) && $stable(o_frag_last) && $stable(o_frag_err))
        else $error("fragment changed under back-pressure");

    no_full_write: assert property (@(posedge aclk) disable iff (i_rst)
        !(fifo_wr && fifo_full))
        else $error("write into a full index FIFO");

    no_empty_rready: assert property (@(posedge aclk) disable iff (i_rst)
        fifo_empty |-> !o_mem_rready)
        else $error("rready raised with an empty index FIFO");

endmodule

bind framebuffer_reader framebuffer_reader_props #(
    .ADDR_WIDTH(ADDR_WIDTH), .PIXEL_WIDTH(PIXEL_WIDTH)
) i_framebuffer_reader_props (
    .aclk(aclk), .i_rst(i_rst), .o_mem_araddr(o_mem_araddr),
    .o_mem_arvalid(o_mem_arvalid), .i_mem_arready(i_mem_arready),
    .o_mem_rready(o_mem_rready), .o_frag_valid(o_frag_valid),
    .i_frag_ready(i_frag_ready), .o_frag_data(o_frag_data),
    .o_frag_index(o_frag_index), .o_frag_last(o_frag_last), .o_frag_err(o_frag_err),
    .fifo_wr(fifo_wr), .fifo_full(fifo_full), .fifo_empty(fifo_empty)
);

// ==== tb/tb_framebuffer_reader.sv ====
//////////////////////////////////////////////////////////////////////
// Framebuffer reader testbench
// Random fetches against a memory responder model, with a reference
// queue that predicts read addresses and fragments
//////////////////////////////////////////////////////////////////////

module tb_framebuffer_reader;

    import fb_axi_pkg::*;

    localparam int SW = 32;
    localparam int AW = 32;
    localparam int PW = 16;
    localparam int DEPTH_LOG2 = 7;
    localparam int TIMEOUT = 5000;
    localparam logic [AW-1:0] BASE = 32'h8000_1000;

    logic aclk = 1'b0;
    logic i_rst;
    logic [AW-1:0] i_conf_addr;
    logic i_fetch_valid;
    logic i_fetch_last;
    logic o_fetch_ready;
    logic [AW-1:0] i_fetch_index;
    logic [AW-1:0] o_mem_araddr;
    logic [AXI_LEN_W-1:0] o_mem_arlen;
    logic o_mem_arvalid;
    logic i_mem_arready;
    logic [SW-1:0] i_mem_rdata;
    axi_resp_e i_mem_rresp;
    logic i_mem_rlast;
    logic i_mem_rvalid;
    logic o_mem_rready;
    logic o_frag_valid;
    logic i_frag_ready;
    logic o_frag_last;
    logic o_frag_err;
    logic [PW-1:0] o_frag_data;
    logic [AW-1:0] o_frag_index;

    integer seed = 54;
    int addr_errs = 0;
    int frag_errs = 0;
    int count_errs = 0;
    int fetch_cnt = 0;
    int read_cnt = 0;
    int frag_cnt = 0;
    bit stall = 1'b0;

    // Reference and responder queues in fetch order
    logic [AW-1:0] exp_idx_q[$];
    bit exp_last_q[$];
    logic [AW-1:0] exp_addr_q[$];
    logic [AW-1:0] ar_q[$];
    axi_resp_e resp_q[$];

    framebuffer_reader #(
        .STREAM_WIDTH(SW), .ADDR_WIDTH(AW), .PIXEL_WIDTH(PW), .FIFO_DEPTH_LOG2(DEPTH_LOG2)
    ) i_framebuffer_reader (.*);

    always #4 aclk = ~aclk;

    // Memory contents are the address mixed with a constant
    function automatic logic [SW-1:0] mem_word(input logic [AW-1:0] addr);
        return addr ^ 32'h5A3C_C3A5;
    endfunction

    function automatic logic [AW-1:0] beat_addr(input logic [AW-1:0] idx);
        return (BASE + idx * (PW / 8)) & ~(AW'(SW / 8 - 1));
    endfunction

    task automatic check_addr(input logic [AW-1:0] got, input logic [AXI_LEN_W-1:0] len,
                              input logic [AW-1:0] exp);
        if (got !== exp || len !== '0) begin
            addr_errs++;
            $display("ERR %0t read address %h len %0d, expected %h len 0",
                     $time, got, len, exp);
        end
    endtask

    task automatic check_frag(input logic [PW-1:0] got_data, input logic [AW-1:0] got_idx,
                              input logic got_last, input logic got_err,
                              input logic [PW-1:0] exp_data, input logic [AW-1:0] exp_idx,
                              input logic exp_last, input axi_resp_e exp_resp);
        logic exp_err;
        exp_err = (exp_resp != OKAY);
        if (got_data !== exp_data || got_idx !== exp_idx || got_last !== exp_last
                || got_err !== exp_err) begin
            frag_errs++;
            $display("ERR %0t fragment %h/%h/%b/%b, expected %h/%h/%b/%b", $time, got_data,
                     got_idx, got_last, got_err, exp_data, exp_idx, exp_last, exp_err);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitors
    //////////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        logic [AW-1:0] idx;
        logic [PW-1:0] pix;
        if (!i_rst && i_fetch_valid && o_fetch_ready) begin
            exp_idx_q.push_back(i_fetch_index);
            exp_last_q.push_back(i_fetch_last);
            fetch_cnt++;
        end
        if (!i_rst && o_mem_arvalid && i_mem_arready) begin
            read_cnt++;
            if (exp_addr_q.size() == 0) begin
                count_errs++;
                $display("Read request issued with no fetch outstanding");
            end else begin
                check_addr(o_mem_araddr, o_mem_arlen, exp_addr_q.pop_front());
            end
        end
        if (!i_rst && o_frag_valid && i_frag_ready) begin
            frag_cnt++;
            if (exp_idx_q.size() == 0 || resp_q.size() == 0) begin
                count_errs++;
                $display("Fragment emitted with no fetch or read outstanding");
            end else begin
                idx = exp_idx_q.pop_front();
                pix = PW'(mem_word(beat_addr(idx)) >> ((idx % (SW / PW)) * PW));
                check_frag(o_frag_data, o_frag_index, o_frag_last, o_frag_err,
                           pix, idx, exp_last_q.pop_front(), resp_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory responder and fragment sink
    //////////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        logic [AW-1:0] a;
        bit beat_busy;
        bit send;
        bit ar_rdy;
        bit fr_rdy;
        axi_resp_e resp;
        beat_busy = i_mem_rvalid && !o_mem_rready;
        if (!i_rst && o_mem_arvalid && i_mem_arready)
            ar_q.push_back(o_mem_araddr);
        // Choices are drawn on the edge and driven just after it
        ar_rdy = (($random(seed) & 3) != 0);
        fr_rdy = (($random(seed) & 3) != 0);
        send = 1'b0;
        if (!beat_busy && ar_q.size() > 0 && ($random(seed) & 3) != 0) begin
            send = 1'b1;
            a = ar_q.pop_front();
            if (($random(seed) & 31) == 0)
                resp = DECERR;
            else if (($random(seed) & 15) == 0)
                resp = SLVERR;
            else
                resp = OKAY;
            resp_q.push_back(resp);
        end
        #1;
        i_mem_arready = ar_rdy;
        i_frag_ready  = stall ? 1'b0 : fr_rdy;
        if (!beat_busy) begin
            i_mem_rvalid = send;
            if (send) begin
                i_mem_rdata = mem_word(a);
                i_mem_rlast = 1'b1;
                i_mem_rresp = resp;
            end
        end
    end

    // Presents a new request and records the read address it must produce
    task automatic drive_fetch(input logic [AW-1:0] idx, input logic last);
        i_fetch_valid = 1'b1;
        i_fetch_index = idx;
        i_fetch_last  = last;
        exp_addr_q.push_back(beat_addr(idx));
    endtask

    task automatic send_fetch(input logic [AW-1:0] idx, input logic last);
        int t;
        t = 0;
        drive_fetch(idx, last);
        @(posedge aclk);
        while (!o_fetch_ready) begin
            t++;
            if (t > TIMEOUT)
                fail_timeout("fetch acceptance");
            @(posedge aclk);
        end
        #1;
        i_fetch_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int t;
        int low_run;
        i_rst = 1'b1;
        i_conf_addr = BASE;
        i_fetch_valid = 1'b0;
        i_fetch_last = 1'b0;
        i_fetch_index = '0;
        i_mem_arready = 1'b0;
        i_mem_rdata = '0;
        i_mem_rresp = OKAY;
        i_mem_rlast = 1'b0;
        i_mem_rvalid = 1'b0;
        i_frag_ready = 1'b0;
        repeat (5) @(posedge aclk);
        #1 i_rst = 1'b0;
        @(posedge aclk);
        if (o_mem_arvalid !== 1'b0 || o_frag_valid !== 1'b0 || o_fetch_ready !== 1'b1) begin
            count_errs++;
            $display("Outputs after reset are not idle");
        end
        #1;

        // Random traffic with back-pressure on both sides
        for (int i = 0; i < 300; i++) begin
            if (($random(seed) & 3) == 0) begin
                @(posedge aclk);
                #1;
            end
            send_fetch(AW'($random(seed) & 32'hFFFF), (i % 8) == 7);
        end

        // Stall the fragment port until the FIFO fills
        @(posedge aclk);
        stall = 1'b1;
        #1;
        drive_fetch(AW'($random(seed) & 32'hFFFF), 1'b0);
        t = 0;
        low_run = 0;
        while (low_run < 32) begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT)
                fail_timeout("o_fetch_ready to fall under a stalled fragment port");
            if (o_fetch_ready) begin
                low_run = 0;
                #1;
                drive_fetch(AW'($random(seed) & 32'hFFFF), 1'b0);
            end else begin
                low_run++;
            end
        end

        // Ready stays low only once the whole FIFO holds waiting reads
        if (fetch_cnt - frag_cnt < (1 << DEPTH_LOG2)) begin
            count_errs++;
            $display("Fetch ready fell with only %0d fetches outstanding",
                     fetch_cnt - frag_cnt);
        end

        // Release the stall and hold the pending fetch until it is accepted
        stall = 1'b0;
        t = 0;
        @(posedge aclk);
        while (!o_fetch_ready) begin
            t++;
            if (t > TIMEOUT)
                fail_timeout("the held fetch to be accepted after the stall");
            @(posedge aclk);
        end
        #1 i_fetch_valid = 1'b0;

        // Drain everything still in flight
        t = 0;
        while (frag_cnt < fetch_cnt) begin
            @(posedge aclk);
            t++;
            if (t > TIMEOUT)
                fail_timeout("outstanding fragments to drain");
        end
        repeat (10) @(posedge aclk);
        if (fetch_cnt != read_cnt || fetch_cnt != frag_cnt) begin
            count_errs++;
            $display("Count mismatch, fetches %0d reads %0d fragments %0d",
                     fetch_cnt, read_cnt, frag_cnt);
        end
        $display("Errors: address %0d, fragment %0d, other %0d (fetches %0d)",
                 addr_errs, frag_errs, count_errs, fetch_cnt);
        if (addr_errs + frag_errs + count_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/fb_axi_pkg.sv
rtl/fb_fetch_pkg.sv
rtl/fetch_broadcast.sv
rtl/fetch_index_fifo.sv
rtl/mem_read_request_gen.sv
rtl/fb_serializer.sv
rtl/framebuffer_reader.sv
tb/framebuffer_reader_props.sv
tb/tb_framebuffer_reader.sv

// ==== Makefile ====
# Verilator build and run of the framebuffer reader testbench

SIM     := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := tb_framebuffer_reader
FLIST   := sources.f

SRCS    := $(shell grep -v '^+' $(FLIST))
OBJDIR  := obj_dir
BIN     := $(OBJDIR)/V$(TOP)
LOG     := sim.log

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# Pass or fail comes from the log
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
